// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbControlUnit
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
FILELIST  := all.f
SOURCES   := $(shell grep -v '^+' $(FILELIST))
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJDIR)

// File: all.f
isaPkg.sv
ctrlPkg.sv
opDecoder.sv
busSequencer.sv
controlWordGen.sv
controlUnit.sv
tbControlUnit.sv

// File: busSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module busSequencer #(
   parameter int unsigned WaitStates = 0
) (
   input  logic            Clock,
   input  logic            nReset,
   input  logic [7:0]      OpcodeCondIn,
   output ctrlPkg::phase_t phase
);

   import isaPkg::*;
   import ctrlPkg::*;

   localparam int CntW = (WaitStates > 0) ? $clog2(WaitStates + 1) : 1;

   opcode_t   opcode;
   logic      memOp;
   logic      waitPhase;
   logic      waitDone;
   logic [CntW-1:0] waitCnt;
   phase_t    nextPhase;

   assign opcode    = opcode_t'(OpcodeCondIn[7:3]);
   assign memOp     = isMemOp(opcode);
   assign waitPhase = (phase == Fet2) || (phase == Exe3); // memory access phases
   assign waitDone  = (waitCnt == CntW'(WaitStates));

   always_comb begin
      case (phase)
         Fet1:    nextPhase = Fet2;
         Fet2:    nextPhase = waitDone ? Fet3 : Fet2;
         Fet3:    nextPhase = Fet4;
         Fet4:    nextPhase = Exe1;
         Exe1:    nextPhase = memOp ? Exe2 : Fet1;
         Exe2:    nextPhase = Exe3;
         Exe3:    nextPhase = waitDone ? Exe4 : Exe3;
         Exe4:    nextPhase = Exe5;
         Exe5:    nextPhase = Fet1;
         default: nextPhase = Fet1;
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         phase   <= Fet1;
         waitCnt <= '0;
      end else begin
         phase <= nextPhase;
         if (waitPhase && !waitDone) begin
            waitCnt <= waitCnt + 1'b1;
         end else begin
            waitCnt <= '0;
         end
      end
   end

   fetchThenExecute: assert property (
      @(posedge Clock) disable iff (!nReset)
      phase == Fet4 |=> phase == Exe1
   );

   // the extended execute is reached only through a memory opcode
   exe2Entry: assert property (
      @(posedge Clock) disable iff (!nReset)
      phase == Exe2 |-> $past(phase == Exe1 && memOp)
   );

endmodule

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit #(
   parameter int unsigned WaitStates = 0
) (
   input  logic             Clock,
   input  logic             nReset,
   input  logic [7:0]       OpcodeCondIn,
   input  logic [3:0]       Flags,
   output ctrlPkg::dpCtrl_t dpCtrl,
   output ctrlPkg::memBus_t memBus
);

   import ctrlPkg::*;

   opAttr_t attr;
   phase_t  phase;

   opDecoder decoder (
      .OpcodeCondIn (OpcodeCondIn),
      .attr         (attr)
   );

   busSequencer #(
      .WaitStates (WaitStates)
   ) sequencer (
      .Clock        (Clock),
      .nReset       (nReset),
      .OpcodeCondIn (OpcodeCondIn),
      .phase        (phase)
   );

   controlWordGen wordGen (
      .Clock        (Clock),
      .nReset       (nReset),
      .OpcodeCondIn (OpcodeCondIn),
      .Flags        (Flags),
      .attr         (attr),
      .phase        (phase),
      .dpCtrl       (dpCtrl),
      .memBus       (memBus)
   );

endmodule

`default_nettype wire

// File: controlWordGen.sv
`timescale 1ns/1ps
`default_nettype none

module controlWordGen (
   input  logic             Clock,
   input  logic             nReset,
   input  logic [7:0]       OpcodeCondIn,
   input  logic [3:0]       Flags,
   input  ctrlPkg::opAttr_t attr,
   input  ctrlPkg::phase_t  phase,
   output ctrlPkg::dpCtrl_t dpCtrl,
   output ctrlPkg::memBus_t memBus
);

   import isaPkg::*;
   import ctrlPkg::*;

   opcode_t    opcode;
   branch_t    branch;
   logic       isLoad;
   logic       isStore;
   logic       flagWe;
   logic       branchTaken;
   logic [FlagV:0] flagReg; // z, n, v

   assign opcode  = opcode_t'(OpcodeCondIn[7:3]);
   assign branch  = branch_t'(OpcodeCondIn[2:0]);
   assign isLoad  = (opcode == LDW);
   assign isStore = (opcode == STW);
   assign flagWe  = (phase == Exe1) && attr.writesFlags;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         flagReg <= '0;
      end else if (flagWe) begin
         flagReg <= Flags[FlagV:0];
      end
   end

   always_comb begin
      case (branch)
         BR, BWL: branchTaken = 1'b1;
         BE:      branchTaken = flagReg[FlagZ];
         BNE:     branchTaken = !flagReg[FlagZ];
         BLT:     branchTaken = flagReg[FlagN] ^ flagReg[FlagV];
         BGE:     branchTaken = !(flagReg[FlagN] ^ flagReg[FlagV]);
         default: branchTaken = 1'b0; // RET and JMP are handled apart
      endcase
   end

   always_comb begin
      dpCtrl        = '0;
      dpCtrl.aluOp  = FnNOP;
      dpCtrl.op1Sel = Op1Rd1;
      dpCtrl.op2Sel = Op2Imm;
      dpCtrl.immSel = ImmLong;
      dpCtrl.rs1Sel = Rs1Ra;
      dpCtrl.wdSel  = WdAlu;
      dpCtrl.pcSel  = Pc1;
      dpCtrl.lrSel  = LrSys;
      memBus        = '0;
      memBus.nME    = 1'b1;

      if (phase inside {Exe1, Exe2}) begin
         dpCtrl.aluOp  = attr.aluOp;
         dpCtrl.op1Sel = attr.op1Sel;
         dpCtrl.op2Sel = attr.op2Sel;
         dpCtrl.immSel = attr.immSel;
         dpCtrl.rs1Sel = attr.rs1Sel;
      end

      case (phase)
         Fet1: begin
            memBus.ale = 1'b1;
            memBus.nWE = 1'b1;
            memBus.nOE = 1'b1;
            dpCtrl.pcEn = 1'b1; // pc onto the address bus
         end
         Fet2: begin
            memBus.nME   = 1'b0;
            memBus.nWE   = 1'b1;
            memBus.memEn = 1'b1;
         end
         Fet3: begin
            memBus.nME   = 1'b0;
            memBus.memEn = 1'b1;
            memBus.enb   = 1'b1;
            memBus.nWE   = 1'b1;
         end
         Fet4: begin
            memBus.nWE   = 1'b1;
            memBus.memEn = 1'b1;
            dpCtrl.irWe  = 1'b1;
         end
         Exe1: begin
            if (isLoad || isStore) begin
               dpCtrl.aluEn = 1'b1; // effective address latched for Exe2
               dpCtrl.aluWe = 1'b1;
            end else if (attr.isBranch) begin
               dpCtrl.pcWe = 1'b1;
               case (branch)
                  RET: begin
                     dpCtrl.lrEn  = 1'b1;
                     dpCtrl.pcSel = PcSysbus;
                  end
                  JMP: begin
                     dpCtrl.aluOp  = FnADD;
                     dpCtrl.op1Sel = Op1Rd1; // register-based target
                     dpCtrl.immSel = ImmShort;
                     dpCtrl.pcSel  = PcAluOut;
                  end
                  default: begin
                     dpCtrl.aluOp  = FnADD;
                     dpCtrl.immSel = ImmLong;
                     dpCtrl.pcSel  = branchTaken ? PcAluOut : Pc1;
                     if (branchTaken && branch == BWL) begin
                        dpCtrl.lrWe  = 1'b1; // return address into link register
                        dpCtrl.lrSel = LrPc;
                     end
                  end
               endcase
            end else begin
               dpCtrl.pcWe  = 1'b1;
               dpCtrl.pcSel = Pc1;
               dpCtrl.regWe = attr.writesReg;
            end
         end
         Exe2: begin
            memBus.ale   = 1'b1;
            memBus.nWE   = 1'b1;
            memBus.nOE   = 1'b1;
            dpCtrl.aluEn = 1'b1; // address out
         end
         Exe3: begin
            dpCtrl.aluOp  = FnA;
            dpCtrl.rs1Sel = Rs1Rd;
            memBus.nME    = 1'b0;
            memBus.nWE    = 1'b1;
            memBus.memEn  = isLoad;
            memBus.nOE    = isStore;
         end
         Exe4: begin
            dpCtrl.aluOp  = FnA;
            dpCtrl.rs1Sel = Rs1Rd;
            memBus.nME    = 1'b0;
            if (isLoad) begin
               memBus.memEn = 1'b1;
               memBus.enb   = 1'b1;
               memBus.nWE   = 1'b1;
            end else begin
               memBus.nOE   = 1'b1;
               dpCtrl.aluEn = 1'b1; // store data held on sysbus
            end
         end
         Exe5: begin
            dpCtrl.pcWe  = 1'b1;
            dpCtrl.pcSel = Pc1;
            if (isLoad) begin
               dpCtrl.regWe = attr.writesReg;
               dpCtrl.wdSel = WdSys;
               memBus.memEn = 1'b1;
               memBus.nWE   = 1'b1;
            end
         end
         default: ;
      endcase
   end

   // address latch and chip enable never overlap
   aleOutsideAccess: assert property (
      @(posedge Clock) disable iff (!nReset)
      !(memBus.ale && !memBus.nME)
   );

   irWriteInFet4: assert property (
      @(posedge Clock) disable iff (!nReset)
      dpCtrl.irWe |-> phase == Fet4
   );

endmodule

`default_nettype wire

// File: ctrlPkg.sv
`default_nettype none

package ctrlPkg;

   // one value per sequencer step
   typedef enum logic [3:0] {
      Fet1,
      Fet2,
      Fet3,
      Fet4,
      Exe1,
      Exe2,
      Exe3,
      Exe4,
      Exe5
   } phase_t;

   // per-instruction attributes from the decoder
   typedef struct packed {
      isaPkg::aluFn_t  aluOp;
      isaPkg::op1Sel_t op1Sel;
      isaPkg::op2Sel_t op2Sel;
      isaPkg::immSel_t immSel;
      isaPkg::rs1Sel_t rs1Sel;
      logic            writesReg;
      logic            writesFlags;
      logic            isBranch;
   } opAttr_t;

   // datapath controls
   typedef struct packed {
      isaPkg::aluFn_t  aluOp;
      isaPkg::op1Sel_t op1Sel;
      isaPkg::op2Sel_t op2Sel;
      isaPkg::immSel_t immSel;
      isaPkg::rs1Sel_t rs1Sel;
      logic            aluEn;
      logic            aluWe;
      logic            lrEn;
      logic            lrWe;
      logic            pcEn;
      logic            pcWe;
      logic            irWe;
      logic            regWe;
      isaPkg::wdSel_t  wdSel;
      isaPkg::pcSel_t  pcSel;
      isaPkg::lrSel_t  lrSel;
   } dpCtrl_t;

   // pad control and memory strobes
   typedef struct packed {
      logic memEn;
      logic ale;
      logic nME;
      logic nOE;
      logic nWE;
      logic enb;
   } memBus_t;

endpackage

`default_nettype wire

// File: isaPkg.sv
`default_nettype none

package isaPkg;

   // major opcode, instruction bits 7:3
   typedef enum logic [4:0] {
      ADD,
      ADDI,
      ADDIB,
      SUB,
      SUBI,
      SUBIB,
      NEG,
      CMP,
      CMPI,
      AND,
      OR,
      XOR,
      NAND,
      NOR,
      NOT,
      LSL,
      LSR,
      ASR,
      LUI,
      LLI,
      LDW,
      STW,
      BRANCH
   } opcode_t; // remaining codes decode as a no-op

   // branch code, instruction bits 2:0
   typedef enum logic [2:0] {
      BR,
      BE,
      BNE,
      BLT,
      BGE,
      BWL, // branch with link
      RET,
      JMP
   } branch_t;

   typedef enum logic [3:0] {
      FnNOP,
      FnADD,
      FnSUB,
      FnNEG,
      FnAND,
      FnOR,
      FnXOR,
      FnNAND,
      FnNOR,
      FnNOT,
      FnLSL,
      FnLSR,
      FnASR,
      FnLUI,
      FnLLI,
      FnA // op1 passed through untouched
   } aluFn_t;

   typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
   typedef enum logic {Op2Imm, Op2Rd2} op2Sel_t;
   typedef enum logic {ImmShort, ImmLong} immSel_t;
   typedef enum logic {Rs1Ra, Rs1Rd} rs1Sel_t;
   typedef enum logic {WdAlu, WdSys} wdSel_t;
   typedef enum logic {LrSys, LrPc} lrSel_t;

   typedef enum logic [1:0] {
      Pc1,      // pc + 1
      PcAluOut,
      PcSysbus
   } pcSel_t;

   // bit positions in the flags word, bit 3 is carry
   localparam int FlagZ = 0;
   localparam int FlagN = 1;
   localparam int FlagV = 2;

   function automatic logic isMemOp(opcode_t op);
      return (op == LDW) || (op == STW);
   endfunction

endpackage

`default_nettype wire

// File: opDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module opDecoder (
   input  logic [7:0]       OpcodeCondIn,
   output ctrlPkg::opAttr_t attr
);

   import isaPkg::*;

   opcode_t opcode;

   assign opcode = opcode_t'(OpcodeCondIn[7:3]);

   always_comb begin
      attr             = '0;
      attr.aluOp       = FnNOP;
      attr.op1Sel      = Op1Rd1;
      attr.op2Sel      = Op2Imm;
      attr.immSel      = ImmLong;
      attr.rs1Sel      = Rs1Ra;
      attr.writesReg   = 1'b0;
      attr.writesFlags = 1'b0;
      attr.isBranch    = (opcode == BRANCH);

      case (opcode)
         ADD, ADDI, ADDIB: attr.aluOp = FnADD;
         SUB, SUBI, SUBIB: attr.aluOp = FnSUB;
         CMP, CMPI:        attr.aluOp = FnSUB;
         NEG:              attr.aluOp = FnNEG;
         AND:              attr.aluOp = FnAND;
         OR:               attr.aluOp = FnOR;
         XOR:              attr.aluOp = FnXOR;
         NAND:             attr.aluOp = FnNAND;
         NOR:              attr.aluOp = FnNOR;
         NOT:              attr.aluOp = FnNOT;
         LSL:              attr.aluOp = FnLSL;
         LSR:              attr.aluOp = FnLSR;
         ASR:              attr.aluOp = FnASR;
         LUI:              attr.aluOp = FnLUI;
         LLI:              attr.aluOp = FnLLI;
         LDW, STW:         attr.aluOp = FnADD; // address = rd1 + offset
         BRANCH:           attr.aluOp = FnADD;
         default:          attr.aluOp = FnNOP;
      endcase

      // operand form
      case (opcode)
         ADD, SUB, CMP, AND, OR, XOR, NAND, NOR: begin
            attr.op2Sel = Op2Rd2;
         end
         ADDI, SUBI, CMPI, LSL, LSR, ASR, LDW, STW: begin
            attr.immSel = ImmShort;
         end
         ADDIB, SUBIB: begin
            attr.rs1Sel = Rs1Rd;
         end
         BRANCH: begin
            attr.op1Sel = Op1Pc; // branch target relative to pc
         end
         default: ;
      endcase

      case (opcode)
         ADD, ADDI, ADDIB, SUB, SUBI, SUBIB, NEG,
         AND, OR, XOR, NAND, NOR, NOT, LSL, LSR, ASR: begin
            attr.writesReg   = 1'b1;
            attr.writesFlags = 1'b1;
         end
         CMP, CMPI: begin
            attr.writesFlags = 1'b1; // compare only updates flags
         end
         LUI, LLI: begin
            attr.writesReg = 1'b1;
         end
         LDW: begin
            attr.writesReg = 1'b1; // written back in Exe5
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: tbControlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tbControlUnit;

   import isaPkg::*;
   import ctrlPkg::*;

   localparam int WaitStates  = 1;
   localparam int ClockPeriod = 100;
   localparam int DriveDelay  = 10;
   localparam int SampleDelay = ClockPeriod - 2 * DriveDelay; // 10 ns before the edge
   localparam int Rounds      = 4; // compare-and-branch rounds
   localparam int NumInstr    = 18 + Rounds * 10 + 2 + 2 + 1 + 1;
   localparam int MaxCycles   = NumInstr * (9 + 2 * WaitStates) + 4 + 20;

   logic        Clock;
   logic        nReset;
   logic [7:0]  OpcodeCondIn;
   logic [3:0]  Flags;
   dpCtrl_t     dpCtrl;
   memBus_t     memBus;
   logic [31:0] rngState;
   logic [2:0]  latched; // z, n, v as loaded by the last compare

   controlUnit #(
      .WaitStates (WaitStates)
   ) dut (
      .Clock        (Clock),
      .nReset       (nReset),
      .OpcodeCondIn (OpcodeCondIn),
      .Flags        (Flags),
      .dpCtrl       (dpCtrl),
      .memBus       (memBus)
   );

   initial begin
      Clock = 1'b0;
      forever #(ClockPeriod / 2) Clock = ~Clock;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // expected strobes in memBus field order
   function automatic memBus_t busWord(input int memEn, ale, nME, nOE, nWE, enb);
      return {memEn[0], ale[0], nME[0], nOE[0], nWE[0], enb[0]};
   endfunction

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   task automatic waitSample();
      #(SampleDelay);
   endtask

   task automatic nextCycle();
      @(posedge Clock);
      #(DriveDelay);
   endtask

   task automatic checkStrobes(input string step, input memBus_t expBus,
                               input int irWe, input int pcWe, input int regWe);
      checkValue({step, " memBus"}, 32'(memBus), 32'(expBus));
      checkValue({step, " irWe"}, 32'(dpCtrl.irWe), irWe);
      checkValue({step, " pcWe"}, 32'(dpCtrl.pcWe), pcWe);
      checkValue({step, " regWe"}, 32'(dpCtrl.regWe), regWe);
   endtask

   task automatic resetTest();
      for (int i = 0; i < 3; i++) begin
         @(negedge Clock);
         checkStrobes("reset", busWord(0, 1, 1, 1, 1, 0), 0, 0, 0); // Fet1 values
      end
      nextCycle(); // four rising edges in reset
      nReset = 1'b1;
   endtask

   task automatic fetch(input logic [7:0] instr);
      OpcodeCondIn = instr;
      rngState = xorshift(rngState);
      Flags = rngState[3:0];
      waitSample();
      checkStrobes("Fet1", busWord(0, 1, 1, 1, 1, 0), 0, 0, 0);
      checkValue("Fet1 pcEn", 32'(dpCtrl.pcEn), 1);
      nextCycle();
      repeat (1 + WaitStates) begin
         waitSample();
         checkStrobes("Fet2", busWord(1, 0, 0, 0, 1, 0), 0, 0, 0);
         nextCycle();
      end
      waitSample();
      checkStrobes("Fet3", busWord(1, 0, 0, 0, 1, 1), 0, 0, 0);
      nextCycle();
      waitSample();
      checkStrobes("Fet4", busWord(1, 0, 1, 0, 1, 0), 1, 0, 0); // last of 4+W fetch cycles
      nextCycle();
   endtask

   task automatic aluTest(input opcode_t op, input aluFn_t fn, input op2Sel_t op2,
                          input immSel_t imm, input int writes);
      string    tag;
      rs1Sel_t  rs1;
      tag = op.name();
      rs1 = (op == ADDIB || op == SUBIB) ? Rs1Rd : Rs1Ra; // b forms read rd
      fetch({op, 3'b000});
      waitSample();
      checkStrobes({tag, " Exe1"}, busWord(0, 0, 1, 0, 0, 0), 0, 1, writes);
      checkValue({tag, " aluOp"}, 32'(dpCtrl.aluOp), 32'(fn));
      checkValue({tag, " op1Sel"}, 32'(dpCtrl.op1Sel), 32'(Op1Rd1));
      checkValue({tag, " op2Sel"}, 32'(dpCtrl.op2Sel), 32'(op2));
      checkValue({tag, " immSel"}, 32'(dpCtrl.immSel), 32'(imm));
      checkValue({tag, " rs1Sel"}, 32'(dpCtrl.rs1Sel), 32'(rs1));
      checkValue({tag, " pcSel"}, 32'(dpCtrl.pcSel), 32'(Pc1));
      nextCycle(); // following fetch checks the return to Fet1
   endtask

   task automatic branchTest(input branch_t code);
      logic  taken;
      string tag;
      tag = code.name();
      case (code)
         BR, BWL: taken = 1'b1;
         BE:      taken = latched[FlagZ];
         BNE:     taken = !latched[FlagZ];
         BLT:     taken = latched[FlagN] != latched[FlagV];
         BGE:     taken = latched[FlagN] == latched[FlagV];
         default: taken = 1'b0;
      endcase
      fetch({BRANCH, code});
      waitSample();
      checkStrobes({tag, " Exe1"}, busWord(0, 0, 1, 0, 0, 0), 0, 1, 0);
      if (code == RET) begin
         checkValue("RET lrEn", 32'(dpCtrl.lrEn), 1);
         checkValue("RET pcSel", 32'(dpCtrl.pcSel), 32'(PcSysbus));
      end else if (code == JMP) begin
         checkValue("JMP pcSel", 32'(dpCtrl.pcSel), 32'(PcAluOut));
         checkValue("JMP immSel", 32'(dpCtrl.immSel), 32'(ImmShort));
         checkValue("JMP op1Sel", 32'(dpCtrl.op1Sel), 32'(Op1Rd1));
      end else begin
         checkValue({tag, " pcSel"}, 32'(dpCtrl.pcSel), taken ? 32'(PcAluOut) : 32'(Pc1));
         checkValue({tag, " lrWe"}, 32'(dpCtrl.lrWe), 32'(taken && code == BWL));
         if (taken) begin
            checkValue({tag, " aluOp"}, 32'(dpCtrl.aluOp), 32'(FnADD));
            checkValue({tag, " immSel"}, 32'(dpCtrl.immSel), 32'(ImmLong));
            checkValue({tag, " op1Sel"}, 32'(dpCtrl.op1Sel), 32'(Op1Pc));
         end
         if (code == BWL) begin
            checkValue("BWL lrSel", 32'(dpCtrl.lrSel), 32'(LrPc));
         end
      end
      nextCycle();
   endtask

   task automatic branchRound(input int round);
      if (round % 2 == 0) begin
         aluTest(CMP, FnSUB, Op2Rd2, ImmLong, 0);
      end else begin
         aluTest(CMPI, FnSUB, Op2Imm, ImmShort, 0);
      end
      latched = Flags[2:0];
      for (int c = 0; c < 8; c++) begin
         branchTest(branch_t'(c[2:0]));
         if (c == 1) begin
            aluTest(LUI, FnLUI, Op2Imm, ImmLong, 1); // flags must survive this
         end
      end
   endtask

   task automatic memTest(input opcode_t op);
      int    ld;
      string tag;
      ld = (op == LDW) ? 1 : 0;
      tag = op.name();
      fetch({op, 3'b000});
      waitSample();
      checkStrobes({tag, " Exe1"}, busWord(0, 0, 1, 0, 0, 0), 0, 0, 0);
      checkValue({tag, " Exe1 aluEn"}, 32'(dpCtrl.aluEn), 1);
      checkValue({tag, " Exe1 aluWe"}, 32'(dpCtrl.aluWe), 1);
      checkValue({tag, " Exe1 aluOp"}, 32'(dpCtrl.aluOp), 32'(FnADD));
      checkValue({tag, " Exe1 immSel"}, 32'(dpCtrl.immSel), 32'(ImmShort));
      nextCycle();
      waitSample();
      checkStrobes({tag, " Exe2"}, busWord(0, 1, 1, 1, 1, 0), 0, 0, 0);
      checkValue({tag, " Exe2 aluEn"}, 32'(dpCtrl.aluEn), 1);
      nextCycle();
      repeat (1 + WaitStates) begin
         waitSample();
         checkStrobes({tag, " Exe3"},
                      ld ? busWord(1, 0, 0, 0, 1, 0) : busWord(0, 0, 0, 1, 1, 0), 0, 0, 0);
         nextCycle();
      end
      waitSample();
      checkStrobes({tag, " Exe4"},
                   ld ? busWord(1, 0, 0, 0, 1, 1) : busWord(0, 0, 0, 1, 0, 0), 0, 0, 0);
      if (ld == 0) begin
         checkValue("STW Exe4 aluEn", 32'(dpCtrl.aluEn), 1); // store data driven
      end
      nextCycle();
      waitSample();
      checkStrobes({tag, " Exe5"},
                   ld ? busWord(1, 0, 1, 0, 1, 0) : busWord(0, 0, 1, 0, 0, 0), 0, 1, ld);
      checkValue({tag, " Exe5 pcSel"}, 32'(dpCtrl.pcSel), 32'(Pc1));
      if (ld != 0) begin
         checkValue("LDW Exe5 wdSel", 32'(dpCtrl.wdSel), 32'(WdSys));
      end
      nextCycle();
   endtask

   task automatic aluOps();
      aluTest(ADD, FnADD, Op2Rd2, ImmLong, 1);
      aluTest(ADDI, FnADD, Op2Imm, ImmShort, 1);
      aluTest(ADDIB, FnADD, Op2Imm, ImmLong, 1);
      aluTest(SUB, FnSUB, Op2Rd2, ImmLong, 1);
      aluTest(SUBI, FnSUB, Op2Imm, ImmShort, 1);
      aluTest(SUBIB, FnSUB, Op2Imm, ImmLong, 1);
      aluTest(NEG, FnNEG, Op2Imm, ImmLong, 1);
      aluTest(CMP, FnSUB, Op2Rd2, ImmLong, 0);
      aluTest(CMPI, FnSUB, Op2Imm, ImmShort, 0);
      aluTest(AND, FnAND, Op2Rd2, ImmLong, 1);
      aluTest(OR, FnOR, Op2Rd2, ImmLong, 1);
      aluTest(XOR, FnXOR, Op2Rd2, ImmLong, 1);
      aluTest(NAND, FnNAND, Op2Rd2, ImmLong, 1);
      aluTest(NOR, FnNOR, Op2Rd2, ImmLong, 1);
      aluTest(NOT, FnNOT, Op2Imm, ImmLong, 1);
      aluTest(LSL, FnLSL, Op2Imm, ImmShort, 1);
      aluTest(LSR, FnLSR, Op2Imm, ImmShort, 1);
      aluTest(ASR, FnASR, Op2Imm, ImmShort, 1);
   endtask

   initial begin
      #(MaxCycles * ClockPeriod);
      $display("simulation timed out after %0d cycles", MaxCycles);
      $display("sim failed");
      $fatal(1);
   end

   initial begin
      nReset       = 1'b0;
      OpcodeCondIn = 8'h00;
      Flags        = 4'h0;
      rngState     = 32'hcda2_11e1;
      latched      = 3'b000;
      resetTest();
      aluOps();
      for (int r = 0; r < Rounds; r++) begin
         branchRound(r);
      end
      memTest(LDW);
      memTest(STW);
      aluTest(LUI, FnLUI, Op2Imm, ImmLong, 1);
      aluTest(LLI, FnLLI, Op2Imm, ImmLong, 1);
      aluTest(opcode_t'(5'h1f), FnNOP, Op2Imm, ImmLong, 0); // undefined opcode
      fetch(8'h00); // Fet1 after the last execute
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire
